// ==== hw/rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Data and address width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define REG_COUNT 32

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

    // Controller phases, one per cycle
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALT      = 3'd5
    } state_e;

    // RV32 major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

endpackage

// ==== hw/rv_dec_if.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

interface rv_dec_if;

    rv_core_pkg::opcode_e  opcode;
    rv_core_pkg::alu_op_e  alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    // Branch flavour, set for BNE
    logic                   is_bne;
    logic                   legal;

    modport dec (
        output opcode, alu_op, rd, rs1, rs2, imm, is_bne, legal
    );

    modport ctrl (
        input opcode, is_bne, legal
    );

    // Shared by fetch, register file and execute
    modport dp (
        input alu_op, rs1, rs2, rd, imm, opcode
    );

endinterface

// ==== hw/rv_fetch.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_fetch (
    input  logic               clk,
    input  logic               rst_i,
    rv_dec_if.dp               dec,
    input  logic               ir_load_i,
    input  logic               pc_load_i,
    input  logic               take_target_i,
    input  logic [`XLEN-1:0]   imem_rdata_i,
    output logic [`XLEN-1:0]   pc_o,
    output logic [`XLEN-1:0]   ir_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] ir_q;
    logic [`XLEN-1:0] pc_next;

    // Branch and jump targets are PC relative
    assign pc_next = take_target_i ? pc_q + dec.imm : pc_q + `XLEN'(4);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
        end else if (pc_load_i) begin
            pc_q <= pc_next;
        end
    end

    // Instruction word arrives one cycle after the request
    always_ff @(posedge clk) begin
        if (ir_load_i) begin
            ir_q <= imem_rdata_i;
        end
    end

    assign pc_o = pc_q;
    assign ir_o = ir_q;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst_i) pc_q[1:0] == 2'b00
    );

endmodule

// ==== hw/rv_decoder.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_decoder (
    input  logic [`XLEN-1:0] ir_i,
    rv_dec_if.dec            dec
);

    rv_core_pkg::opcode_e opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [`XLEN-1:0]     imm_i;
    logic [`XLEN-1:0]     imm_s;
    logic [`XLEN-1:0]     imm_b;
    logic [`XLEN-1:0]     imm_u;
    logic [`XLEN-1:0]     imm_j;

    assign opcode = rv_core_pkg::opcode_e'(ir_i[6:0]);
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    assign dec.opcode = opcode;
    assign dec.rd     = ir_i[11:7];
    assign dec.rs1    = ir_i[19:15];
    assign dec.rs2    = ir_i[24:20];
    assign dec.is_bne = funct3[0];

    // Sign-extended immediates per format
    assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u = {ir_i[31:12], 12'b0};
    assign imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    always_comb begin
        dec.imm    = imm_i;
        dec.alu_op = rv_core_pkg::ALU_ADD;
        dec.legal  = 1'b0;
        case (opcode)
            rv_core_pkg::OP_LUI: begin
                dec.imm    = imm_u;
                dec.alu_op = rv_core_pkg::ALU_PASS_B;
                dec.legal  = 1'b1;
            end
            rv_core_pkg::OP_IMM: begin
                // ADDI only
                dec.legal = (funct3 == 3'b000);
            end
            rv_core_pkg::OP_REG: begin
                dec.legal = (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        dec.alu_op = funct7[5] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                        dec.legal  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    3'b010:  dec.alu_op = rv_core_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = rv_core_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = rv_core_pkg::ALU_OR;
                    3'b111:  dec.alu_op = rv_core_pkg::ALU_AND;
                    default: dec.legal  = 1'b0;
                endcase
            end
            rv_core_pkg::OP_LOAD: begin
                // Word access only
                dec.legal = (funct3 == 3'b010);
            end
            rv_core_pkg::OP_STORE: begin
                dec.imm   = imm_s;
                dec.legal = (funct3 == 3'b010);
            end
            rv_core_pkg::OP_BRANCH: begin
                dec.imm    = imm_b;
                dec.alu_op = rv_core_pkg::ALU_SUB;
                dec.legal  = (funct3 == 3'b000) || (funct3 == 3'b001);
            end
            rv_core_pkg::OP_JAL: begin
                dec.imm   = imm_j;
                dec.legal = 1'b1;
            end
            rv_core_pkg::OP_SYSTEM: begin
                // EBREAK, anything else in this class halts as illegal
                dec.legal = (ir_i[31:7] == 25'h0002000);
            end
            default: dec.legal = 1'b0;
        endcase
    end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_regfile (
    input  logic             clk,
    rv_dec_if.dp             dec,
    input  logic             we_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic [`XLEN-1:0] rdata1_o,
    output logic [`XLEN-1:0] rdata2_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 writes are dropped
    always_ff @(posedge clk) begin
        if (we_i && dec.rd != '0) begin
            regs[dec.rd] <= wdata_i;
        end
    end

    // x0 always reads as zero, even before any write
    assign rdata1_o = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rdata2_o = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_execute (
    input  logic             clk,
    input  logic             rst_i,
    rv_dec_if.dp             dec,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rdata1_i,
    input  logic [`XLEN-1:0] rdata2_i,
    input  logic             res_load_i,
    input  logic [`XLEN-1:0] dmem_rdata_i,
    output logic             cmp_eq_o,
    output logic [`XLEN-1:0] result_o,
    output logic [`XLEN-1:0] wb_data_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] result_q;
    logic             cmp_eq_q;

    // Operand select by instruction class
    always_comb begin
        op_a = rdata1_i;
        op_b = rdata2_i;
        case (dec.opcode)
            rv_core_pkg::OP_IMM,
            rv_core_pkg::OP_LUI,
            rv_core_pkg::OP_LOAD,
            rv_core_pkg::OP_STORE: op_b = dec.imm;
            rv_core_pkg::OP_JAL: begin
                // Link address
                op_a = pc_i;
                op_b = `XLEN'(4);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            rv_core_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_core_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_core_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_core_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_core_pkg::ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:                 alu_res = op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (res_load_i) begin
            result_q <= alu_res;
        end
    end

    // Branch condition, held until writeback
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cmp_eq_q <= 1'b0;
        end else if (res_load_i) begin
            cmp_eq_q <= (rdata1_i == rdata2_i);
        end
    end

    assign cmp_eq_o  = cmp_eq_q;
    assign result_o  = result_q;
    assign wb_data_o = (dec.opcode == rv_core_pkg::OP_LOAD) ? dmem_rdata_i : result_q;

endmodule

// ==== hw/rv_controller.sv ====
`timescale 1ns/10ps

module rv_controller (
    input  logic  clk,
    input  logic  rst_i,
    rv_dec_if.ctrl dec,
    input  logic  cmp_eq_i,
    output logic  ir_load_o,
    output logic  res_load_o,
    output logic  pc_load_o,
    output logic  take_target_o,
    output logic  rf_we_o,
    output logic  imem_req_o,
    output logic  dmem_req_o,
    output logic  dmem_we_o,
    output logic  retire_o,
    output logic  halted_o
);

    rv_core_pkg::state_e state_q;
    rv_core_pkg::state_e state_d;
    logic                boot_q;
    logic                is_mem;
    logic                writes_rd;
    logic                br_taken;

    assign is_mem = (dec.opcode == rv_core_pkg::OP_LOAD) ||
                    (dec.opcode == rv_core_pkg::OP_STORE);

    assign writes_rd = (dec.opcode == rv_core_pkg::OP_LUI) ||
                       (dec.opcode == rv_core_pkg::OP_IMM) ||
                       (dec.opcode == rv_core_pkg::OP_REG) ||
                       (dec.opcode == rv_core_pkg::OP_LOAD) ||
                       (dec.opcode == rv_core_pkg::OP_JAL);

    // BEQ on equal, BNE on not equal
    assign br_taken = (dec.opcode == rv_core_pkg::OP_BRANCH) && (cmp_eq_i ^ dec.is_bne);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_core_pkg::FETCH:  state_d = boot_q ? rv_core_pkg::FETCH : rv_core_pkg::DECODE;
            rv_core_pkg::DECODE: state_d = rv_core_pkg::EXECUTE;
            rv_core_pkg::EXECUTE: begin
                // Instruction register is valid from here on
                if (!dec.legal || dec.opcode == rv_core_pkg::OP_SYSTEM) begin
                    state_d = rv_core_pkg::HALT;
                end else if (is_mem) begin
                    state_d = rv_core_pkg::MEMORY;
                end else begin
                    state_d = rv_core_pkg::WRITEBACK;
                end
            end
            rv_core_pkg::MEMORY:    state_d = rv_core_pkg::WRITEBACK;
            rv_core_pkg::WRITEBACK: state_d = rv_core_pkg::FETCH;
            default:                state_d = rv_core_pkg::HALT;
        endcase
    end

    // First fetch waits for the cycle after reset release
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= rv_core_pkg::FETCH;
            boot_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            boot_q  <= 1'b0;
        end
    end

    assign imem_req_o    = (state_q == rv_core_pkg::FETCH) && !boot_q;
    assign ir_load_o     = (state_q == rv_core_pkg::DECODE);
    assign res_load_o    = (state_q == rv_core_pkg::EXECUTE);
    assign dmem_req_o    = (state_q == rv_core_pkg::MEMORY);
    assign dmem_we_o     = dmem_req_o && (dec.opcode == rv_core_pkg::OP_STORE);
    assign retire_o      = (state_q == rv_core_pkg::WRITEBACK);
    assign pc_load_o     = retire_o;
    assign rf_we_o       = retire_o && writes_rd;
    assign take_target_o = retire_o && (br_taken || dec.opcode == rv_core_pkg::OP_JAL);
    assign halted_o      = (state_q == rv_core_pkg::HALT);

    // Retire follows execute of a non-memory op, or a memory access
    a_wb_only: assert property (
        @(posedge clk) disable iff (rst_i)
        (rf_we_o || retire_o) |->
            $past(state_q == rv_core_pkg::EXECUTE && !is_mem) ||
            $past(state_q) == rv_core_pkg::MEMORY
    );

    // Memory access always directly follows execute
    a_dmem_after_exec: assert property (
        @(posedge clk) disable iff (rst_i)
        dmem_req_o |-> $past(state_q) == rv_core_pkg::EXECUTE
    );

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (rst_i)
        halted_o |=> halted_o
    );

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_i,
    // Instruction memory
    output logic                   imem_req_o,
    output logic [`XLEN-1:0]       imem_addr_o,
    input  logic [`XLEN-1:0]       imem_rdata_i,
    // Data memory
    output logic                   dmem_req_o,
    output logic                   dmem_we_o,
    output logic [`XLEN-1:0]       dmem_addr_o,
    output logic [`XLEN-1:0]       dmem_wdata_o,
    input  logic [`XLEN-1:0]       dmem_rdata_i,
    // Retire port
    output logic                   retire_o,
    output logic [`XLEN-1:0]       retire_pc_o,
    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]       rf_wdata_o,
    output logic                   halted_o
);

    logic             ir_load;
    logic             res_load;
    logic             pc_load;
    logic             take_target;
    logic             rf_we;
    logic             cmp_eq;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] ir;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] wb_data;

    rv_dec_if dec_bus ();

    rv_controller u_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .dec           (dec_bus.ctrl),
        .cmp_eq_i      (cmp_eq),
        .ir_load_o     (ir_load),
        .res_load_o    (res_load),
        .pc_load_o     (pc_load),
        .take_target_o (take_target),
        .rf_we_o       (rf_we),
        .imem_req_o    (imem_req_o),
        .dmem_req_o    (dmem_req_o),
        .dmem_we_o     (dmem_we_o),
        .retire_o      (retire_o),
        .halted_o      (halted_o)
    );

    rv_fetch u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .dec           (dec_bus.dp),
        .ir_load_i     (ir_load),
        .pc_load_i     (pc_load),
        .take_target_i (take_target),
        .imem_rdata_i  (imem_rdata_i),
        .pc_o          (pc),
        .ir_o          (ir)
    );

    rv_decoder u_dec (
        .ir_i (ir),
        .dec  (dec_bus.dec)
    );

    rv_regfile u_rf (
        .clk      (clk),
        .dec      (dec_bus.dp),
        .we_i     (rf_we),
        .wdata_i  (wb_data),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    rv_execute u_exec (
        .clk          (clk),
        .rst_i        (rst_i),
        .dec          (dec_bus.dp),
        .pc_i         (pc),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .res_load_i   (res_load),
        .dmem_rdata_i (dmem_rdata_i),
        .cmp_eq_o     (cmp_eq),
        .result_o     (result),
        .wb_data_o    (wb_data)
    );

    // Result register doubles as the data address
    assign imem_addr_o  = pc;
    assign dmem_addr_o  = result;
    assign dmem_wdata_o = rdata2;

    assign retire_pc_o  = pc;
    assign rf_we_o      = rf_we;
    assign rf_waddr_o   = dec_bus.rd;
    assign rf_wdata_o   = wb_data;

endmodule

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module tb_rv_core;

    localparam int PERIOD = 40;
    localparam int MEM_WORDS = 256;
    // Upper bounds over all runs, sizing the watchdog
    localparam int INSTR_TOTAL = 100;
    localparam int RUNS = 7;
    localparam int WATCHDOG_CYCLES = INSTR_TOTAL * 5 + RUNS * 20 + 50;

    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    // Register ops coded as {sub flag, funct3}
    localparam logic [3:0] K_ADD = 4'h0;
    localparam logic [3:0] K_SUB = 4'h8;
    localparam logic [3:0] K_SLT = 4'h2;
    localparam logic [3:0] K_XOR = 4'h4;
    localparam logic [3:0] K_OR = 4'h6;
    localparam logic [3:0] K_AND = 4'h7;

    logic                   clk;
    logic                   rst_i;
    logic                   imem_req_o;
    logic [`XLEN-1:0]       imem_addr_o;
    logic [`XLEN-1:0]       imem_rdata_i;
    logic                   dmem_req_o;
    logic                   dmem_we_o;
    logic [`XLEN-1:0]       dmem_addr_o;
    logic [`XLEN-1:0]       dmem_wdata_o;
    logic [`XLEN-1:0]       dmem_rdata_i;
    logic                   retire_o;
    logic [`XLEN-1:0]       retire_pc_o;
    logic                   rf_we_o;
    logic [`REG_ADDR_W-1:0] rf_waddr_o;
    logic [`XLEN-1:0]       rf_wdata_o;
    logic                   halted_o;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] model_regs [32];

    // Expected retires in program order
    logic [31:0] exp_pc [$];
    logic        exp_we [$];
    logic [4:0]  exp_waddr [$];
    logic [31:0] exp_wdata [$];
    int          exp_len [$];
    // Expected data memory accesses
    logic        exp_mwe [$];
    logic [31:0] exp_maddr [$];
    logic [31:0] exp_mdata [$];

    logic [31:0] asm_pc;
    int          cyc;
    int          last_req_cyc;
    int          last_len;
    logic        first_fetch;
    logic        prev_halted;
    int          value_errors;
    int          other_errors;

    rv_core DUT (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .retire_o     (retire_o),
        .retire_pc_o  (retire_pc_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .rf_wdata_o   (rf_wdata_o),
        .halted_o     (halted_o)
    );

    always #(PERIOD/2) clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            value_errors++;
            $display("error: %s = %h, expected %h", name, got, want);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            other_errors++;
            $display("check failed at cycle %0d: %s", cyc, what);
        end
    endtask

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // Places one instruction and records what its retire must show
    task automatic emit_instr(input logic [31:0] word, input logic we, input logic [4:0] rd,
                              input logic [31:0] val, input int len);
        imem[asm_pc[9:2]] = word;
        exp_pc.push_back(asm_pc);
        exp_we.push_back(we);
        exp_waddr.push_back(rd);
        exp_wdata.push_back(val);
        exp_len.push_back(len);
        if (we && rd != 5'd0)
            model_regs[rd] = val;
        asm_pc = asm_pc + 32'd4;
    endtask

    // Words that must never retire
    task automatic place_raw(input logic [31:0] word);
        imem[asm_pc[9:2]] = word;
        asm_pc = asm_pc + 32'd4;
    endtask

    task automatic addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [11:0] imm);
        emit_instr(i_word(imm, rs1, 3'b000, rd, OPC_IMM), 1'b1, rd,
                   model_regs[rs1] + sext12(imm), 4);
    endtask

    task automatic rtype_instr(input logic [3:0] kind, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (kind)
            K_ADD: val = a + b;
            K_SUB: val = a - b;
            K_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_XOR: val = a ^ b;
            K_OR: val = a | b;
            K_AND: val = a & b;
            default: val = 'x;
        endcase
        emit_instr(r_word(kind[3] ? 7'h20 : 7'h00, rs2, rs1, kind[2:0], rd), 1'b1, rd, val, 4);
    endtask

    task automatic lui_instr(input logic [4:0] rd, input logic [19:0] imm);
        emit_instr({imm, rd, OPC_LUI}, 1'b1, rd, {imm, 12'h000}, 4);
    endtask

    task automatic sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sext12(imm);
        exp_mwe.push_back(1'b1);
        exp_maddr.push_back(addr);
        exp_mdata.push_back(model_regs[rs2]);
        ref_mem[addr[9:2]] = model_regs[rs2];
        emit_instr(s_word(imm, rs2, rs1), 1'b0, 5'd0, 32'd0, 5);
    endtask

    task automatic lw_instr(input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sext12(imm);
        exp_mwe.push_back(1'b0);
        exp_maddr.push_back(addr);
        exp_mdata.push_back(32'd0);
        emit_instr(i_word(imm, rs1, 3'b010, rd, OPC_LOAD), 1'b1, rd, ref_mem[addr[9:2]], 5);
    endtask

    task automatic branch_instr(input logic bne, input logic [4:0] rs1, input logic [4:0] rs2,
                                input logic [12:0] off);
        logic [31:0] pc;
        logic        taken;
        pc = asm_pc;
        taken = (model_regs[rs1] == model_regs[rs2]) ^ bne;
        emit_instr(b_word(off, rs2, rs1, {2'b00, bne}), 1'b0, 5'd0, 32'd0, 4);
        if (taken)
            asm_pc = pc + {{19{off[12]}}, off};
    endtask

    task automatic jal_instr(input logic [4:0] rd, input logic [20:0] off);
        logic [31:0] pc;
        pc = asm_pc;
        emit_instr(j_word(off, rd), 1'b1, rd, pc + 32'd4, 4);
        asm_pc = pc + {{11{off[20]}}, off};
    endtask

    task automatic check_retire();
        logic [31:0] pc;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] val;
        int          len;
        if (exp_pc.size() == 0) begin
            expect_true(1'b0, "retire_o pulsed with no instruction left to retire");
        end else begin
            pc = exp_pc.pop_front();
            we = exp_we.pop_front();
            rd = exp_waddr.pop_front();
            val = exp_wdata.pop_front();
            len = exp_len.pop_front();
            expect_true(cyc - last_req_cyc == len - 1, "retire_o late or early after its fetch");
            compare_value("retire_pc_o", retire_pc_o, pc);
            compare_value("rf_we_o", rf_we_o, we);
            if (we) begin
                compare_value("rf_waddr_o", rf_waddr_o, rd);
                compare_value("rf_wdata_o", rf_wdata_o, val);
            end
            last_len = len;
        end
    endtask

    task automatic check_dmem();
        logic        we;
        logic [31:0] addr;
        logic [31:0] data;
        if (exp_maddr.size() == 0) begin
            expect_true(1'b0, "data memory request with no load or store pending");
        end else begin
            we = exp_mwe.pop_front();
            addr = exp_maddr.pop_front();
            data = exp_mdata.pop_front();
            compare_value("dmem_we_o", dmem_we_o, we);
            compare_value("dmem_addr_o", dmem_addr_o, addr);
            if (we)
                compare_value("dmem_wdata_o", dmem_wdata_o, data);
        end
    endtask

    // Monitor and memory models, sampling where DUT outputs are stable
    always @(negedge clk) begin
        cyc++;
        if (rst_i) begin
            // First fetch is due in the cycle after release
            prev_halted = 1'b0;
            first_fetch = 1'b1;
            last_req_cyc = cyc;
        end else begin
            if (prev_halted)
                expect_true(halted_o, "halted_o fell without a reset");
            if (halted_o)
                expect_true(!imem_req_o && !dmem_req_o && !retire_o,
                            "request or retire seen while halted");
            if (imem_req_o) begin
                if (first_fetch) begin
                    expect_true(cyc - last_req_cyc == 1,
                                "first fetch not in the first cycle after reset");
                    compare_value("imem_addr_o", imem_addr_o, `RESET_PC);
                end else begin
                    expect_true(cyc - last_req_cyc == last_len,
                                "fetch spacing differs from the instruction length");
                end
                first_fetch = 1'b0;
                last_req_cyc = cyc;
            end
            if (retire_o)
                check_retire();
            if (dmem_req_o)
                check_dmem();
            prev_halted = halted_o;
        end
        if (imem_req_o)
            imem_rdata_i <= imem[imem_addr_o[9:2]];
        if (dmem_req_o) begin
            if (dmem_we_o)
                dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
            else
                dmem_rdata_i <= dmem[dmem_addr_o[9:2]];
        end
    end

    task automatic start_program();
        logic [31:0] a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = i;
            // Unused opcode 7'h7f halts the core if ever fetched
            imem[i] = {a[24:0], 7'h7f};
            dmem[i] = {~a[15:0], a[15:0]};
            ref_mem[i] = {~a[15:0], a[15:0]};
        end
        exp_pc.delete();
        exp_we.delete();
        exp_waddr.delete();
        exp_wdata.delete();
        exp_len.delete();
        exp_mwe.delete();
        exp_maddr.delete();
        exp_mdata.delete();
        asm_pc = `RESET_PC;
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_i <= 1'b1;
        repeat (3) @(negedge clk);
        expect_true(!imem_req_o && !dmem_req_o && !dmem_we_o && !retire_o && !rf_we_o &&
                    !halted_o, "control outputs not low in reset");
        rst_i <= 1'b0;
    endtask

    task automatic run_program();
        reset_dut();
        @(negedge clk);
        while (!halted_o)
            @(negedge clk);
        repeat (8) @(negedge clk);
        expect_true(exp_pc.size() == 0, "core halted before all instructions retired");
        expect_true(exp_maddr.size() == 0, "a load or store never reached data memory");
    endtask

    task automatic arith_test();
        start_program();
        addi_instr(5'd1, 5'd0, 12'd100);
        addi_instr(5'd2, 5'd0, 12'hff9);
        rtype_instr(K_ADD, 5'd3, 5'd1, 5'd2);
        rtype_instr(K_SUB, 5'd4, 5'd2, 5'd1);
        rtype_instr(K_AND, 5'd5, 5'd1, 5'd2);
        rtype_instr(K_OR, 5'd6, 5'd1, 5'd2);
        rtype_instr(K_XOR, 5'd7, 5'd1, 5'd2);
        rtype_instr(K_SLT, 5'd8, 5'd2, 5'd1);
        rtype_instr(K_SLT, 5'd9, 5'd1, 5'd2);
        addi_instr(5'd10, 5'd2, 12'h830);
        place_raw(EBREAK_WORD);
        run_program();
    endtask

    task automatic lui_x0_test();
        start_program();
        lui_instr(5'd5, 20'h12345);
        lui_instr(5'd0, 20'habcde);
        rtype_instr(K_ADD, 5'd6, 5'd0, 5'd5);
        rtype_instr(K_ADD, 5'd7, 5'd0, 5'd0);
        place_raw(EBREAK_WORD);
        run_program();
    endtask

    task automatic mem_test();
        start_program();
        addi_instr(5'd1, 5'd0, 12'h100);
        addi_instr(5'd2, 5'd0, 12'h5a5);
        lui_instr(5'd3, 20'hcafe0);
        addi_instr(5'd3, 5'd3, 12'h123);
        sw_instr(5'd2, 5'd1, 12'd8);
        sw_instr(5'd3, 5'd1, 12'hffc);
        lw_instr(5'd4, 5'd1, 12'd8);
        lw_instr(5'd5, 5'd1, 12'hffc);
        lw_instr(5'd6, 5'd1, 12'd16);
        place_raw(EBREAK_WORD);
        run_program();
    endtask

    task automatic branch_jal_test();
        start_program();
        addi_instr(5'd1, 5'd0, 12'd5);
        addi_instr(5'd2, 5'd0, 12'd5);
        addi_instr(5'd3, 5'd0, 12'd9);
        branch_instr(1'b0, 5'd1, 5'd2, 13'd8);
        branch_instr(1'b0, 5'd1, 5'd3, 13'd8);
        branch_instr(1'b1, 5'd1, 5'd3, 13'd12);
        branch_instr(1'b1, 5'd1, 5'd2, 13'd8);
        jal_instr(5'd4, 21'd16);
        addi_instr(5'd6, 5'd4, 12'd1);
        place_raw(EBREAK_WORD);
        run_program();
    endtask

    task automatic halt_test();
        // SLL is outside the supported set
        start_program();
        addi_instr(5'd1, 5'd0, 12'd1);
        place_raw(r_word(7'h00, 5'd2, 5'd1, 3'b001, 5'd5));
        run_program();
        // AUIPC opcode is unsupported as a whole
        start_program();
        addi_instr(5'd1, 5'd0, 12'd2);
        place_raw({20'h00001, 5'd3, 7'b0010111});
        run_program();
    endtask

    task automatic random_test();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        start_program();
        for (int r = 1; r < 8; r++) begin
            rnd = $urandom();
            lui_instr(5'(r), rnd[31:12]);
            addi_instr(5'(r), 5'(r), rnd[11:0]);
        end
        for (int n = 0; n < 20; n++) begin
            rnd = $urandom();
            rd = 5'($urandom_range(7, 1));
            rs1 = 5'($urandom_range(7, 0));
            rs2 = 5'($urandom_range(7, 0));
            if (rnd[31])
                addi_instr(rd, rs1, rnd[11:0]);
            else
                rtype_instr(K_ADD, rd, rs1, rs2);
        end
        place_raw(EBREAK_WORD);
        run_program();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        imem_rdata_i = '0;
        dmem_rdata_i = '0;
        value_errors = 0;
        other_errors = 0;
        cyc = 0;
        last_req_cyc = 0;
        last_len = 4;
        first_fetch = 1'b0;
        prev_halted = 1'b0;
        model_regs[0] = 32'd0;
        void'($urandom(32'h6030b9a0));
        arith_test();
        lui_x0_test();
        mem_test();
        branch_jal_test();
        halt_test();
        random_test();
        $display("tests done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_dec_if.sv
hw/rv_fetch.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_controller.sv
hw/rv_core.sv
bench/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_core_pkg.sv
      - hw/rv_dec_if.sv
      - hw/rv_fetch.sv
      - hw/rv_decoder.sv
      - hw/rv_regfile.sv
      - hw/rv_execute.sv
      - hw/rv_controller.sv
      - hw/rv_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/tb_rv_core.sv
